//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

  // byte address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // unmapped mips segments
  localparam addr_t kseg0_base = 32'h8000_0000;
  localparam addr_t kseg1_base = 32'hA000_0000;
  localparam addr_t seg_size   = 32'h2000_0000;

  // axi read encodings
  typedef logic [7:0] axi_len_t;
  localparam logic [1:0] axi_burst_incr = 2'b01;
  localparam logic [2:0] axi_size_word  = 3'b010;

  // one memory read, len is beats minus one
  typedef struct packed {
    logic     req;
    addr_t    addr;
    axi_len_t len;
  } mem_req_t;

  typedef struct packed {
    logic  addr_ok;
    logic  data_ok;
    word_t rdata;
  } mem_resp_t;

  typedef struct packed {
    logic [3:0] arid;
    addr_t      araddr;
    axi_len_t   arlen;
    logic [2:0] arsize;
    logic [1:0] arburst;
    logic       arvalid;
  } axi_ar_t;

  typedef struct packed {
    word_t rdata;
    logic  rlast;
    logic  rvalid;
  } axi_r_t;

endpackage

`default_nettype wire

//--- source/seg_router.sv
`timescale 1ns/1ps
`default_nettype none

module seg_router #(
  parameter int line_words = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                cpu_req,
  input  fetch_pkg::addr_t    cpu_addr,
  output logic                cpu_addr_ok,
  output logic                cpu_data_ok,
  output fetch_pkg::word_t    cpu_rdata,
  output logic                cpu_addr_err,
  output fetch_pkg::mem_req_t cache_req,
  input  fetch_pkg::mem_resp_t cache_resp,
  input  fetch_pkg::mem_req_t refill_req,
  output fetch_pkg::mem_req_t mem_req,
  input  fetch_pkg::mem_resp_t mem_resp,
  output fetch_pkg::mem_resp_t refill_resp
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    k_cached,
    k_uncached,
    k_error
  } kind_t;

  logic     in_kseg0;
  logic     in_kseg1;
  kind_t    kind_d;
  kind_t    kind_q;
  addr_t    paddr;
  addr_t    paddr_q;
  logic     busy;
  logic     unc_pend;
  logic     accept;
  axi_len_t burst_len;

  // fixed segment translation
  assign in_kseg0 = (cpu_addr >= kseg0_base) && (cpu_addr < kseg1_base);
  assign in_kseg1 = (cpu_addr >= kseg1_base) && (cpu_addr < kseg1_base + seg_size);
  assign paddr    = cpu_addr & (seg_size - 32'd1);

  always_comb begin
    if (in_kseg0) begin
      kind_d = k_cached;
    end else if (in_kseg1) begin
      kind_d = k_uncached;
    end else begin
      kind_d = k_error;
    end
  end

  // free only while nothing is in flight
  assign cpu_addr_ok = !busy && ((kind_d != k_cached) || cache_resp.addr_ok);
  assign accept      = cpu_req && cpu_addr_ok;

  assign cache_req.req  = cpu_req && !busy && (kind_d == k_cached);
  assign cache_req.addr = paddr;
  assign cache_req.len  = '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      unc_pend <= 1'b0;
      kind_q   <= k_error;
    end else if (accept) begin
      busy     <= 1'b1;
      kind_q   <= kind_d;
      unc_pend <= (kind_d == k_uncached);
    end else begin
      if (cpu_data_ok) begin
        busy <= 1'b0;
      end
      // bridge took the single beat read
      if (mem_resp.addr_ok) begin
        unc_pend <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      paddr_q <= paddr;
    end
  end

  // request side muxes, line burst or single beat
  assign burst_len = (kind_q == k_cached) ? axi_len_t'(line_words - 1) : '0;

  always_comb begin
    if (kind_q == k_cached) begin
      mem_req.req  = refill_req.req;
      mem_req.addr = refill_req.addr;
    end else begin
      mem_req.req  = unc_pend;
      mem_req.addr = paddr_q;
    end
    mem_req.len = burst_len;
  end

  assign refill_resp = (kind_q == k_cached) ? mem_resp : '0;

  // response side muxes
  always_comb begin
    case (kind_q)
      k_cached: begin
        cpu_data_ok = busy && cache_resp.data_ok;
        cpu_rdata   = cache_resp.rdata;
      end
      k_uncached: begin
        cpu_data_ok = busy && mem_resp.data_ok;
        cpu_rdata   = mem_resp.rdata;
      end
      default: begin
        // address error answers one cycle after accept
        cpu_data_ok = busy;
        cpu_rdata   = '0;
      end
    endcase
  end

  assign cpu_addr_err = busy && (kind_q == k_error);

endmodule

`default_nettype wire

//--- source/icache.sv
`timescale 1ns/1ps
`default_nettype none

module icache #(
  parameter int line_words = 8,
  parameter int num_lines  = 64
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  fetch_pkg::mem_req_t  cache_req,
  output fetch_pkg::mem_resp_t cache_resp,
  output fetch_pkg::mem_req_t  refill_req,
  input  fetch_pkg::mem_resp_t refill_resp
);
  import fetch_pkg::*;

  localparam int off_w = $clog2(line_words);
  localparam int idx_w = $clog2(num_lines);
  localparam int tag_w = 32 - 2 - off_w - idx_w;
  localparam logic [off_w-1:0] last_beat = off_w'(line_words - 1);

  typedef enum logic [2:0] {
    s_idle,
    s_lookup,
    s_fill_addr,
    s_fill_data,
    s_done
  } state_t;

  state_t state;
  addr_t  addr_q;

  logic [idx_w-1:0] idx;
  logic [off_w-1:0] off;
  logic [tag_w-1:0] tag;
  logic             hit;
  logic [off_w-1:0] beat_cnt;
  logic             fill_beat;
  logic             fill_last;

  logic [num_lines-1:0] valid;
  logic [tag_w-1:0]     tag_mem  [num_lines];
  word_t                data_mem [num_lines * line_words];

  // fields of the registered physical address
  assign off = addr_q[2 +: off_w];
  assign idx = addr_q[2 + off_w +: idx_w];
  assign tag = addr_q[31 -: tag_w];

  assign hit       = valid[idx] && (tag_mem[idx] == tag);
  assign fill_beat = (state == s_fill_data) && refill_resp.data_ok;
  assign fill_last = fill_beat && (beat_cnt == last_beat);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= s_idle;
      valid    <= '0;
      beat_cnt <= '0;
    end else begin
      case (state)
        s_idle: begin
          if (cache_req.req) begin
            state <= s_lookup;
          end
        end
        s_lookup: begin
          if (hit) begin
            state <= s_idle;
          end else begin
            // line is overwritten, drop it until the fill ends
            valid[idx] <= 1'b0;
            state      <= s_fill_addr;
          end
        end
        s_fill_addr: begin
          beat_cnt <= '0;
          if (refill_resp.addr_ok) begin
            state <= s_fill_data;
          end
        end
        s_fill_data: begin
          if (fill_beat) begin
            beat_cnt <= beat_cnt + 1'b1;
          end
          if (fill_last) begin
            valid[idx] <= 1'b1;
            state      <= s_done;
          end
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if ((state == s_idle) && cache_req.req) begin
      addr_q <= cache_req.addr;
    end
    // beats land at incrementing word offsets
    if (fill_beat) begin
      data_mem[{idx, beat_cnt}] <= refill_resp.rdata;
    end
    if (fill_last) begin
      tag_mem[idx] <= tag;
    end
  end

  assign cache_resp.addr_ok = (state == s_idle);
  assign cache_resp.data_ok = ((state == s_lookup) && hit) || (state == s_done);
  assign cache_resp.rdata   = data_mem[{idx, off}];

  // line aligned burst of line_words beats
  assign refill_req.req  = (state == s_fill_addr);
  assign refill_req.addr = {addr_q[31:2 + off_w], {(off_w + 2){1'b0}}};
  assign refill_req.len  = axi_len_t'(line_words - 1);

endmodule

`default_nettype wire

//--- source/axi_read_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi_read_bridge (
  input  logic                 clk,
  input  logic                 rst_n,
  input  fetch_pkg::mem_req_t  req,
  output fetch_pkg::mem_resp_t resp,
  output fetch_pkg::axi_ar_t   ar,
  input  logic                 arready,
  input  fetch_pkg::axi_r_t    r,
  output logic                 rready
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    s_idle,
    s_addr,
    s_data
  } state_t;

  state_t   state;
  addr_t    addr_q;
  axi_len_t len_q;
  logic     ar_done;
  logic     r_beat;

  assign ar_done = (state == s_addr) && arready;
  assign r_beat  = (state == s_data) && r.rvalid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= s_idle;
    end else begin
      case (state)
        s_idle: begin
          if (req.req) begin
            state <= s_addr;
          end
        end
        s_addr: begin
          if (arready) begin
            state <= s_data;
          end
        end
        s_data: begin
          // burst ends on the beat flagged rlast
          if (r.rvalid && r.rlast) begin
            state <= s_idle;
          end
        end
        default: begin
          state <= s_idle;
        end
      endcase
    end
  end

  // address and length held for the whole burst
  always_ff @(posedge clk) begin
    if ((state == s_idle) && req.req) begin
      addr_q <= req.addr;
      len_q  <= req.len;
    end
  end

  assign ar.arid    = '0;
  assign ar.araddr  = addr_q;
  assign ar.arlen   = len_q;
  assign ar.arsize  = axi_size_word;
  assign ar.arburst = axi_burst_incr;
  assign ar.arvalid = (state == s_addr);

  assign rready = (state == s_data);

  // one addr_ok per AR handshake, one data_ok per beat
  assign resp.addr_ok = ar_done;
  assign resp.data_ok = r_beat;
  assign resp.rdata   = r.rdata;

endmodule

`default_nettype wire

//--- source/fetch_front_top.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_front_top #(
  parameter int line_words = 8,
  parameter int num_lines  = 64
) (
  input  logic              clk,
  input  logic              rst_n,
  // sram-like fetch port
  input  logic              cpu_req,
  input  fetch_pkg::addr_t  cpu_addr,
  output logic              cpu_addr_ok,
  output logic              cpu_data_ok,
  output fetch_pkg::word_t  cpu_rdata,
  output logic              cpu_addr_err,
  // axi read channels
  output fetch_pkg::axi_ar_t ar,
  input  logic              arready,
  input  fetch_pkg::axi_r_t r,
  output logic              rready
);
  import fetch_pkg::*;

  mem_req_t  cache_req;
  mem_resp_t cache_resp;
  mem_req_t  refill_req;
  mem_resp_t refill_resp;
  // shared path toward the bridge
  mem_req_t  mem_req;
  mem_resp_t mem_resp;

  seg_router #(
    .line_words (line_words)
  ) router_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cpu_req      (cpu_req),
    .cpu_addr     (cpu_addr),
    .cpu_addr_ok  (cpu_addr_ok),
    .cpu_data_ok  (cpu_data_ok),
    .cpu_rdata    (cpu_rdata),
    .cpu_addr_err (cpu_addr_err),
    .cache_req    (cache_req),
    .cache_resp   (cache_resp),
    .refill_req   (refill_req),
    .mem_req      (mem_req),
    .mem_resp     (mem_resp),
    .refill_resp  (refill_resp)
  );

  icache #(
    .line_words (line_words),
    .num_lines  (num_lines)
  ) icache_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cache_req   (cache_req),
    .cache_resp  (cache_resp),
    .refill_req  (refill_req),
    .refill_resp (refill_resp)
  );

  axi_read_bridge bridge_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .req     (mem_req),
    .resp    (mem_resp),
    .ar      (ar),
    .arready (arready),
    .r       (r),
    .rready  (rready)
  );

endmodule

`default_nettype wire

//--- dv/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int half_period  = 4,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

  // release on a falling edge, like every other input
  initial begin
    rst_n = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- dv/fetch_front_assert.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_front_assert (
  input logic                 clk,
  input logic                 rst_n,
  input fetch_pkg::axi_ar_t   ar,
  input logic                 arready,
  input logic                 rready,
  input fetch_pkg::mem_resp_t resp
);

  // address phase holds until the slave takes it
  ar_held: assert property (@(posedge clk) disable iff (!rst_n)
    ar.arvalid && !arready |=> ar.arvalid && $stable(ar.araddr))
    else $error("arvalid dropped or araddr changed before arready");

  no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
    !(rready && ar.arvalid))
    else $error("rready high while arvalid is still pending");

  // rready is high exactly in the data state
  beat_in_data: assert property (@(posedge clk) disable iff (!rst_n)
    resp.data_ok |-> rready)
    else $error("bridge data_ok outside the data state");

endmodule

bind axi_read_bridge fetch_front_assert assert_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .ar      (ar),
  .arready (arready),
  .rready  (rready),
  .resp    (resp)
);

`default_nettype wire

//--- dv/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;
  import fetch_pkg::*;

  typedef enum int {
    c_error,
    c_uncached,
    c_miss,
    c_hit
  } class_t;

  typedef struct packed {
    addr_t  va;
    class_t cls;
  } entry_t;

  localparam int num_entries = 20;

  logic    clk;
  logic    rst_n;
  logic    cpu_req;
  addr_t   cpu_addr;
  logic    cpu_addr_ok;
  logic    cpu_data_ok;
  word_t   cpu_rdata;
  logic    cpu_addr_err;
  axi_ar_t ar;
  logic    arready;
  axi_r_t  r;
  logic    rready;

  entry_t stim [num_entries];
  int     errors = 0;
  int     checks = 0;
  int     cycle = 0;
  int     lw;
  int     nl;
  int     tag_shadow [int];

  // axi memory model state
  int          ar_count = 0;
  addr_t       last_araddr;
  axi_len_t    last_arlen;
  logic [3:0]  last_arid;
  logic [2:0]  last_arsize;
  logic [1:0]  last_arburst;
  int          last_beat_cyc = 0;
  logic        burst_active = 1'b0;
  addr_t       cur_addr = '0;
  int          beats_left = 0;
  logic [31:0] rng;

  tb_clock clock_i (
    .clk   (clk),
    .rst_n (rst_n)
  );

  fetch_front_top dut_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cpu_req      (cpu_req),
    .cpu_addr     (cpu_addr),
    .cpu_addr_ok  (cpu_addr_ok),
    .cpu_data_ok  (cpu_data_ok),
    .cpu_rdata    (cpu_rdata),
    .cpu_addr_err (cpu_addr_err),
    .ar           (ar),
    .arready      (arready),
    .r            (r),
    .rready       (rready)
  );

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input bit ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("CHECK FAILED at %0t ns: %s", $time, msg);
      errors++;
    end
  endtask

  // handshakes seen at the rising edge
  always @(posedge clk) begin
    if (ar.arvalid && arready) begin
      ar_count++;
      last_araddr  = ar.araddr;
      last_arlen   = ar.arlen;
      last_arid    = ar.arid;
      last_arsize  = ar.arsize;
      last_arburst = ar.arburst;
      cur_addr     = ar.araddr;
      beats_left   = int'(ar.arlen) + 1;
      burst_active = 1'b1;
    end
    if (r.rvalid && rready) begin
      last_beat_cyc = cycle;
      cur_addr      = cur_addr + 32'd4;
      beats_left--;
      if (beats_left == 0) begin
        burst_active = 1'b0;
      end
    end
  end

  // memory answers byte address A with ~A, random stalls on both channels
  initial begin
    arready = 1'b0;
    r       = '0;
    rng     = 32'd60298;
    forever begin
      @(negedge clk);
      rng      = xorshift(rng);
      arready  = (rng[1:0] != 2'b00);
      rng      = xorshift(rng);
      r.rvalid = burst_active && (rng[1:0] != 2'b00);
      r.rdata  = ~cur_addr;
      r.rlast  = (beats_left == 1);
    end
  end

  task automatic load_table();
    stim[0]  = '{32'hA000_0100, c_uncached};
    stim[1]  = '{32'h8000_0040, c_miss};
    stim[2]  = '{32'h8000_0044, c_hit};
    stim[3]  = '{32'h8000_005C, c_hit};
    stim[4]  = '{32'h8000_0048, c_hit};
    stim[5]  = '{32'h7FFF_FFFC, c_error};
    stim[6]  = '{32'h0000_1000, c_error};
    stim[7]  = '{32'hC000_0000, c_error};
    stim[8]  = '{32'hFFFF_FFF0, c_error};
    stim[9]  = '{32'hA000_1234, c_uncached};
    // same index as 0x8000_0040, other tag
    stim[10] = '{32'h8000_0840, c_miss};
    stim[11] = '{32'h8000_0844, c_hit};
    stim[12] = '{32'h8000_0040, c_miss};
    stim[13] = '{32'h8000_0058, c_hit};
    stim[14] = '{32'h9FFF_FFFC, c_miss};
    stim[15] = '{32'h9FFF_FFE0, c_hit};
    stim[16] = '{32'hBFFF_FFFC, c_uncached};
    stim[17] = '{32'h8000_0060, c_miss};
    stim[18] = '{32'h8000_007C, c_hit};
    stim[19] = '{32'hA000_0040, c_uncached};
  endtask

  // segment rules plus a shadow of the cache tags
  function automatic class_t predict_class(input addr_t va);
    addr_t line;
    int    idx;
    int    tag;
    bit    hit;
    if (va >= kseg1_base && va < kseg1_base + seg_size) begin
      return c_uncached;
    end
    if (va < kseg0_base || va >= kseg1_base) begin
      return c_error;
    end
    line = (va - kseg0_base) / addr_t'(lw * 4);
    idx  = int'(line % addr_t'(nl));
    tag  = int'(line / addr_t'(nl));
    hit  = tag_shadow.exists(idx) && (tag_shadow[idx] == tag);
    tag_shadow[idx] = tag;
    return hit ? c_hit : c_miss;
  endfunction

  task automatic run_entry(input entry_t e);
    addr_t pa;
    int    ar_before;
    int    waits;
    int    t_accept;
    int    t_done;
    word_t got;
    logic  got_err;
    pa = e.va & (seg_size - 32'd1);
    check(predict_class(e.va) == e.cls,
          $sformatf("table class for %h disagrees with the tag shadow", e.va));
    ar_before = ar_count;
    @(negedge clk);
    cpu_req  = 1'b1;
    cpu_addr = e.va;
    waits    = 0;
    do begin
      @(posedge clk);
      waits++;
    end while (!cpu_addr_ok);
    t_accept = cycle;
    check(waits == 1, $sformatf("%h addr_ok %0d cycles after the request", e.va, waits - 1));
    @(negedge clk);
    cpu_req = 1'b0;
    do @(posedge clk); while (!cpu_data_ok);
    t_done  = cycle;
    got     = cpu_rdata;
    got_err = cpu_addr_err;
    @(negedge clk);
    check(!cpu_data_ok, $sformatf("%h data_ok held for more than one cycle", e.va));
    if (e.cls == c_error) begin
      check(got_err, $sformatf("%h gave no address error", e.va));
      check(got == '0, $sformatf("%h error rdata %h not zero", e.va, got));
    end else begin
      check(!got_err, $sformatf("%h gave an address error", e.va));
      check(got == ~pa, $sformatf("%h rdata %h, expected %h", e.va, got, ~pa));
    end
    if (e.cls == c_error || e.cls == c_hit) begin
      check(ar_count == ar_before, $sformatf("%h issued an AR", e.va));
      check(t_done - t_accept == 1,
            $sformatf("%h data_ok %0d cycles after addr_ok", e.va, t_done - t_accept));
    end else begin
      check(ar_count == ar_before + 1,
            $sformatf("%h issued %0d ARs", e.va, ar_count - ar_before));
      // id 0, 4-byte beats, INCR burst
      check(last_arid == 4'd0 && last_arsize == 3'd2 && last_arburst == 2'd1,
            $sformatf("%h AR id %0d size %0d burst %0d",
                      e.va, last_arid, last_arsize, last_arburst));
    end
    if (e.cls == c_miss) begin
      check(int'(last_arlen) == lw - 1, $sformatf("%h arlen %0d", e.va, last_arlen));
      check(last_araddr == (pa & ~(addr_t'(lw * 4) - 32'd1)),
            $sformatf("%h refill araddr %h not line aligned", e.va, last_araddr));
      check(t_done == last_beat_cyc + 1, $sformatf("%h data_ok not 1 cycle after rlast", e.va));
    end
    if (e.cls == c_uncached) begin
      check(last_arlen == '0, $sformatf("%h uncached arlen %0d", e.va, last_arlen));
      check(last_araddr == pa, $sformatf("%h uncached araddr %h", e.va, last_araddr));
      check(t_done == last_beat_cyc, $sformatf("%h data_ok not in the beat cycle", e.va));
    end
  endtask

  initial begin
    cpu_req  = 1'b0;
    cpu_addr = '0;
    lw       = dut_i.line_words;
    nl       = dut_i.num_lines;
    load_table();
    wait (rst_n === 1'b1);
    @(negedge clk);
    check(!cpu_data_ok && !ar.arvalid && !rready, "outputs not idle after reset");
    for (int i = 0; i < num_entries; i++) begin
      run_entry(stim[i]);
    end
    repeat (4) @(negedge clk);
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // worst case a full refill per entry with heavy stalls
  initial begin
    int limit;
    limit = num_entries * (dut_i.line_words + 1) * 20;
    while (cycle < limit) @(posedge clk);
    $display("timeout: the fetch sequence did not finish within %0d cycles", limit);
    $display("%0d checks, %0d errors", checks, errors);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
source/fetch_pkg.sv
source/seg_router.sv
source/icache.sv
source/axi_read_bridge.sv
source/fetch_front_top.sv
dv/tb_clock.sv
dv/fetch_front_assert.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# compile and run the fetch front end testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_top \
  -f vlog.f --Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/tb_top_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failed" "$log"; then
  exit 1
fi
exit 0
